// File: hw/periph_pkg.sv
// Peripheral subsystem package: address map, size codes, request and select structs
`default_nettype none

package periph_pkg;

    // Number of byte-wide edge-counter peripherals
    localparam int NUM_SIMPLE = 8;

    // Request address width, bit 8 splits GPIO from counter space
    localparam int ADDR_W = 9;

    // GPIO register offsets
    localparam logic [5:0] GPIO_OUT_OFS   = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS    = 6'h04;
    localparam logic [5:0] GPIO_FSEL_BASE = 6'h20;

    // Counter register offsets
    localparam logic [3:0] CNT_REG_PIN     = 4'd0;
    localparam logic [3:0] CNT_REG_COUNT   = 4'd1;
    localparam logic [3:0] CNT_REG_PATTERN = 4'd2;

    // Output function select codes
    localparam logic [3:0] FSEL_GPIO     = 4'd0;
    localparam logic [3:0] FSEL_CNT_BASE = 4'd8;

    // Access size, all ones means no access
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10,
        SZ_NONE = 2'b11
    } size_code_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        size_code_t        wsize;
        size_code_t        rsize;
    } periph_req_t;

    typedef struct packed {
        logic                  gpio;
        logic [NUM_SIMPLE-1:0] cnt;
        logic [3:0]            reg_ofs;
    } periph_sel_t;

endpackage

`default_nettype wire

// File: hw/periph_decoder.sv
// Address and access size decoder producing block selects and write strobes
`default_nettype none

module periph_decoder (
    input  periph_pkg::periph_req_t req,
    output periph_pkg::periph_sel_t sel,
    output logic [7:0]              cnt_wr,
    output logic                    gpio_wr
);
    import periph_pkg::*;

    logic is_cnt;
    logic wr_any;

    // Top address bit picks the counter space
    assign is_cnt = req.addr[ADDR_W-1];
    assign wr_any = req.wsize != SZ_NONE;

    always_comb begin
        sel         = '0;
        sel.gpio    = !is_cnt;
        sel.reg_ofs = req.addr[3:0];
        if (is_cnt) begin
            sel.cnt[req.addr[6:4]] = 1'b1;
        end
    end

    assign gpio_wr = sel.gpio && wr_any;

    // Counters take byte writes only, other sizes are dropped here
    assign cnt_wr = (req.wsize == SZ_BYTE) ? sel.cnt : 8'h00;

    // At most one counter selected, never together with GPIO, strobes within select
    always_comb begin
        a_sel_onehot: assert ($onehot0(sel.cnt) && !(sel.gpio && |sel.cnt)
                              && ((cnt_wr & ~sel.cnt) == 8'h00));
    end

endmodule

`default_nettype wire

// File: hw/edge_counter_periph.sv
// Byte-access edge counter peripheral with pin select, wrapping count and output pattern
`default_nettype none

module edge_counter_periph (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] ui_sync,
    input  logic [3:0] reg_ofs,
    input  logic       wr,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic [7:0] pattern
);
    import periph_pkg::*;

    logic [2:0] pin_sel;
    logic [7:0] count;
    logic [7:0] prev_sync;
    logic       rise;

    // Previous sample of the synchronized pins for edge detection
    always_ff @(posedge clk) begin
        prev_sync <= ui_sync;
    end

    assign rise = ui_sync[pin_sel] && !prev_sync[pin_sel];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel <= '0;
            count   <= '0;
            pattern <= '0;
        end else begin
            if (wr && reg_ofs == CNT_REG_PIN) begin
                pin_sel <= wdata[2:0];
            end
            if (wr && reg_ofs == CNT_REG_PATTERN) begin
                pattern <= wdata;
            end
            // Any write to the count register clears it, ahead of an edge
            if (wr && reg_ofs == CNT_REG_COUNT) begin
                count <= '0;
            end else if (rise) begin
                count <= count + 8'd1;
            end
        end
    end

    always_comb begin
        case (reg_ofs)
            CNT_REG_PIN:     rdata = {5'b0, pin_sel};
            CNT_REG_COUNT:   rdata = count;
            CNT_REG_PATTERN: rdata = pattern;
            default:         rdata = 8'h00;
        endcase
    end

    a_count_step: assert property (@(posedge clk) disable iff (!rst_n)
        count == $past(count) || count == 8'(($past(count) + 8'd1)) || count == 8'd0);

endmodule

`default_nettype wire

// File: hw/gpio_ctrl.sv
// GPIO output register, input readback, per-pin function selects and output pin mux
`default_nettype none

module gpio_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_sel_t sel,
    input  logic [5:0]              addr,
    input  logic                    wr,
    input  logic [31:0]             wdata,
    input  logic [7:0]              ui_sync,
    input  logic [7:0][7:0]         patterns,
    output logic [31:0]             rdata,
    output logic [7:0]              uo_out
);
    import periph_pkg::*;

    logic [7:0]      gpio_out;
    logic [7:0][3:0] fsel;
    logic            is_fsel;
    logic [2:0]      fsel_idx;

    // Function selects sit one word apart from the base
    assign is_fsel  = addr[5] == GPIO_FSEL_BASE[5] && addr[1:0] == 2'b00;
    assign fsel_idx = addr[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            fsel     <= {8{FSEL_GPIO}};
        end else if (wr) begin
            if (addr == GPIO_OUT_OFS) begin
                gpio_out <= wdata[7:0];
            end
            if (is_fsel) begin
                fsel[fsel_idx] <= wdata[3:0];
            end
        end
    end

    always_comb begin
        rdata = 32'h0;
        if (sel.gpio) begin
            if (addr == GPIO_OUT_OFS) begin
                rdata = {24'h0, gpio_out};
            end else if (addr == GPIO_IN_OFS) begin
                rdata = {24'h0, ui_sync};
            end else if (is_fsel) begin
                rdata = {28'h0, fsel[fsel_idx]};
            end
        end
    end

    // Pin k takes bit k of the GPIO register or of the chosen counter's pattern
    always_comb begin
        logic [3:0] slot;
        uo_out = 8'h00;
        slot   = 4'h0;
        for (int i = 0; i < 8; i++) begin
            slot = fsel[i] - FSEL_CNT_BASE;
            if (fsel[i] == FSEL_GPIO) begin
                uo_out[i] = gpio_out[i];
            end else if (fsel[i] >= FSEL_CNT_BASE) begin
                uo_out[i] = patterns[slot[2:0]][i];
            end else begin
                // Codes 1 to 7 are unassigned
                uo_out[i] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/periph_readback.sv
// Read data mux, registered and held data_out, and data_ready generation
`default_nettype none

module periph_readback (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_req_t req,
    input  periph_pkg::periph_sel_t sel,
    input  logic [31:0]             gpio_rdata,
    input  logic [7:0][7:0]         cnt_rdata,
    input  logic                    data_read_complete,
    output logic [31:0]             data_out,
    output logic                    data_ready
);
    import periph_pkg::*;

    logic [31:0] rd_word;
    logic [31:0] data_q;
    logic        hold;
    logic        ready_q;
    logic        read_req;
    logic        write_req;
    logic        capture;

    assign read_req  = req.rsize != SZ_NONE;
    assign write_req = req.wsize != SZ_NONE;

    // Counter bytes are zero-extended into the word
    always_comb begin
        rd_word = 32'h0;
        if (sel.gpio) begin
            rd_word = gpio_rdata;
        end else begin
            for (int i = 0; i < NUM_SIMPLE; i++) begin
                if (sel.cnt[i]) begin
                    rd_word = {24'h0, cnt_rdata[i]};
                end
            end
        end
    end

    // No new capture while a result waits for data_read_complete
    assign capture = read_req && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= capture;
            if (capture) begin
                hold <= 1'b1;
            end else if (data_read_complete) begin
                hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= rd_word;
        end
    end

    assign data_out = data_q;

    // Writes complete in the cycle they are presented
    assign data_ready = ready_q || write_req;

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(data_out));

endmodule

`default_nettype wire

// File: hw/periph_top.sv
// Peripheral subsystem top with the decoder, edge counters, GPIO block and readback
`default_nettype none

module periph_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              ui_in,
    input  periph_pkg::periph_req_t req,
    input  logic                    data_read_complete,
    output logic [7:0]              uo_out,
    output logic [31:0]             data_out,
    output logic                    data_ready
);
    import periph_pkg::*;

    periph_sel_t                 sel;
    logic [NUM_SIMPLE-1:0]       cnt_wr;
    logic                        gpio_wr;
    logic [7:0]                  ui_sync;
    logic [NUM_SIMPLE-1:0][7:0]  cnt_rdata;
    logic [NUM_SIMPLE-1:0][7:0]  patterns;
    logic [31:0]                 gpio_rdata;

    // Input pins sampled once for the counters and the GPIO readback
    always_ff @(posedge clk) begin
        ui_sync <= ui_in;
    end

    periph_decoder u_decoder (
        .req     (req),
        .sel     (sel),
        .cnt_wr  (cnt_wr),
        .gpio_wr (gpio_wr)
    );

    for (genvar i = 0; i < NUM_SIMPLE; i++) begin : g_cnt
        edge_counter_periph u_cnt (
            .clk     (clk),
            .rst_n   (rst_n),
            .ui_sync (ui_sync),
            .reg_ofs (sel.reg_ofs),
            .wr      (cnt_wr[i]),
            .wdata   (req.wdata[7:0]),
            .rdata   (cnt_rdata[i]),
            .pattern (patterns[i])
        );
    end

    gpio_ctrl u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (sel),
        .addr     (req.addr[5:0]),
        .wr       (gpio_wr),
        .wdata    (req.wdata),
        .ui_sync  (ui_sync),
        .patterns (patterns),
        .rdata    (gpio_rdata),
        .uo_out   (uo_out)
    );

    periph_readback u_readback (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .sel                (sel),
        .gpio_rdata         (gpio_rdata),
        .cnt_rdata          (cnt_rdata),
        .data_read_complete (data_read_complete),
        .data_out           (data_out),
        .data_ready         (data_ready)
    );

endmodule

`default_nettype wire

// File: verif/periph_tb.sv
// Testbench for the peripheral subsystem: clock, reset, LFSR, bus tasks, stimulus, checks, report
`default_nettype none

module periph_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import periph_pkg::*;

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    periph_req_t req;
    logic        data_read_complete;
    logic [7:0]  uo_out;
    logic [31:0] data_out;
    logic        data_ready;

    // Reference model of the output pin state
    logic [7:0]  m_gpio;
    logic [3:0]  m_fsel [8];
    logic [7:0]  m_pat [8];
    logic [7:0]  exp_uo;
    logic        expect_hold;
    logic [31:0] lfsr_state;
    string       test_name;
    int          errors;
    int          test_errs0;
    int          tests_run;
    int          tests_failed;
    event        timeout_ev;

    periph_top DUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .ui_in              (ui_in),
        .req                (req),
        .data_read_complete (data_read_complete),
        .uo_out             (uo_out),
        .data_out           (data_out),
        .data_ready         (data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic note_error(input string what, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("In test %s: %s", test_name, msg);
    endtask

    a_write_ready: assert property (@(posedge clk) disable iff (!rst_n)
        req.wsize != SZ_NONE |-> data_ready)
        else note_failure("data_ready was low during a write");

    a_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req.rsize != SZ_NONE) && req.wsize == SZ_NONE |-> !data_ready ##1 data_ready)
        else note_failure("data_ready did not rise exactly one cycle after the read began");

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        expect_hold |=> $stable(data_out))
        else note_failure("data_out changed while the read result was held");

    a_uo_model: assert property (@(posedge clk) disable iff (!rst_n) uo_out == exp_uo)
        else note_error("uo_out", {24'h0, $sampled(exp_uo)}, {24'h0, $sampled(uo_out)});

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        nb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            nb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], nb};
            v = {v[30:0], nb};
        end
        return v;
    endfunction

    function automatic periph_req_t idle_req();
        return '{addr: 9'h0, wdata: 32'h0, wsize: SZ_NONE, rsize: SZ_NONE};
    endfunction

    function automatic logic [8:0] cnt_addr(input logic [2:0] slot, input logic [3:0] ofs);
        return {2'b10, slot, ofs};
    endfunction

    function automatic logic [8:0] fsel_addr(input int k);
        return 9'(GPIO_FSEL_BASE) + 9'(4 * k);
    endfunction

    // Pin k shows GPIO bit k, bit k of a counter pattern, or 0 for unused codes
    function automatic logic [7:0] uo_model();
        logic [7:0] v;
        v = 8'h00;
        for (int k = 0; k < 8; k++) begin
            if (m_fsel[k] == FSEL_GPIO) begin
                v[k] = m_gpio[k];
            end else if (m_fsel[k] >= FSEL_CNT_BASE) begin
                v[k] = m_pat[m_fsel[k][2:0]][k];
            end
        end
        return v;
    endfunction

    task automatic update_model(input logic [8:0] addr, input logic [31:0] wdata,
                                input size_code_t size);
        if (addr[8]) begin
            if (size == SZ_BYTE && addr[3:0] == CNT_REG_PATTERN) begin
                m_pat[addr[6:4]] = wdata[7:0];
            end
        end else if (addr[5:0] == GPIO_OUT_OFS) begin
            m_gpio = wdata[7:0];
        end else if (addr[5] && addr[1:0] == 2'b00) begin
            m_fsel[addr[4:2]] = wdata[3:0];
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: data_ready never came during a %s in test %s", what, test_name);
        -> timeout_ev;
        forever @(posedge clk);
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!data_ready && n < 20);
        if (!data_ready) begin
            report_timeout(what);
        end
    endtask

    task automatic bus_write(input logic [8:0] addr, input logic [31:0] wdata,
                             input size_code_t size);
        @(posedge clk);
        req <= '{addr: addr, wdata: wdata, wsize: size, rsize: SZ_NONE};
        wait_ready("write");
        @(posedge clk);
        req <= idle_req();
        update_model(addr, wdata, size);
        exp_uo <= uo_model();
    endtask

    task automatic bus_read(input logic [8:0] addr, output logic [31:0] data);
        @(posedge clk);
        req <= '{addr: addr, wdata: 32'h0, wsize: SZ_NONE, rsize: SZ_WORD};
        wait_ready("read");
        data = data_out;
        @(posedge clk);
        req <= idle_req();
        data_read_complete <= 1'b1;
        @(posedge clk);
        data_read_complete <= 1'b0;
    endtask

    task automatic check_read(input logic [8:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        bus_read(addr, got);
        a_read_value: assert (got === exp)
            else note_error($sformatf("read of %h", addr), exp, got);
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        test_errs0 = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errs0) begin
            tests_failed++;
            $display("Test %s: FAILED", test_name);
        end else begin
            $display("Test %s: ok", test_name);
        end
    endtask

    initial begin
        @(timeout_ev);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [7:0]  v;
        logic [7:0]  old_v;
        logic [2:0]  slot;
        logic [2:0]  pin;
        logic [31:0] first;
        int          npulse;
        rst_n = 1'b0;
        ui_in = 8'h00;
        req = idle_req();
        data_read_complete = 1'b0;
        expect_hold = 1'b0;
        exp_uo = 8'h00;
        m_gpio = 8'h00;
        for (int k = 0; k < 8; k++) begin
            m_fsel[k] = FSEL_GPIO;
            m_pat[k]  = 8'h00;
        end
        lfsr_state = 32'he2d9_59e9;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset");
        @(negedge clk);
        a_reset_state: assert (uo_out == 8'h00 && !data_ready)
            else note_error("uo_out and data_ready", 32'h0, {23'h0, data_ready, uo_out});
        check_read(9'(GPIO_OUT_OFS), 32'h0);
        for (int k = 0; k < 8; k++) begin
            check_read(fsel_addr(k), 32'h0);
        end
        end_test();

        begin_test("gpio");
        v = 8'(rand_bits(8));
        bus_write(9'(GPIO_OUT_OFS), {24'h0, v}, SZ_WORD);
        check_read(9'(GPIO_OUT_OFS), {24'h0, v});
        v = 8'(rand_bits(8));
        @(posedge clk);
        ui_in <= v;
        check_read(9'(GPIO_IN_OFS), {24'h0, v});
        end_test();

        begin_test("pattern");
        for (int k = 0; k < 8; k++) begin
            v = 8'(rand_bits(8));
            bus_write(cnt_addr(3'(k), CNT_REG_PATTERN), {24'h0, v}, SZ_BYTE);
            check_read(cnt_addr(3'(k), CNT_REG_PATTERN), {24'h0, v});
            bus_write(fsel_addr(k), {28'h0, FSEL_CNT_BASE + 4'(k)}, SZ_WORD);
            bus_write(fsel_addr(k), {28'h0, FSEL_GPIO}, SZ_WORD);
        end
        end_test();

        begin_test("edges");
        slot = 3'(rand_bits(3));
        pin = 3'(rand_bits(3));
        npulse = 1 + int'(rand_bits(4));
        @(posedge clk);
        ui_in <= 8'h00;
        bus_write(cnt_addr(slot, CNT_REG_PIN), {29'h0, pin}, SZ_BYTE);
        bus_write(cnt_addr(slot, CNT_REG_COUNT), 32'h0, SZ_BYTE);
        for (int n = 0; n < npulse; n++) begin
            @(posedge clk);
            ui_in <= 8'h01 << pin;
            @(posedge clk);
            @(posedge clk);
            ui_in <= 8'h00;
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        check_read(cnt_addr(slot, CNT_REG_COUNT), 32'(npulse));
        bus_write(cnt_addr(slot, CNT_REG_COUNT), 32'h5a, SZ_BYTE);
        check_read(cnt_addr(slot, CNT_REG_COUNT), 32'h0);
        end_test();

        begin_test("hold");
        @(posedge clk);
        req <= '{addr: 9'(GPIO_OUT_OFS), wdata: 32'h0, wsize: SZ_NONE, rsize: SZ_WORD};
        wait_ready("read");
        first = data_out;
        a_first_value: assert (first == {24'h0, m_gpio})
            else note_error("first read", {24'h0, m_gpio}, first);
        // Keep the read asserted on other addresses while completion is withheld
        repeat (4) begin
            @(posedge clk);
            req.addr <= cnt_addr(3'(rand_bits(3)), CNT_REG_PATTERN);
            expect_hold <= 1'b1;
            @(negedge clk);
            a_held_value: assert (data_out == first)
                else note_error("held data_out", first, data_out);
        end
        @(posedge clk);
        req <= idle_req();
        data_read_complete <= 1'b1;
        expect_hold <= 1'b0;
        @(posedge clk);
        data_read_complete <= 1'b0;
        end_test();

        begin_test("size");
        slot = 3'(rand_bits(3));
        old_v = 8'(rand_bits(8));
        v = old_v ^ (8'(rand_bits(8)) | 8'h01);
        bus_write(cnt_addr(slot, CNT_REG_PATTERN), {24'h0, old_v}, SZ_BYTE);
        bus_write(cnt_addr(slot, CNT_REG_PATTERN), {24'h0, v}, SZ_WORD);
        check_read(cnt_addr(slot, CNT_REG_PATTERN), {24'h0, old_v});
        bus_write(cnt_addr(slot, CNT_REG_PATTERN), {24'h0, v}, SZ_BYTE);
        check_read(cnt_addr(slot, CNT_REG_PATTERN), {24'h0, v});
        end_test();

        repeat (2) @(posedge clk);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hw/periph_pkg.sv
hw/periph_decoder.sv
hw/edge_counter_periph.sv
hw/gpio_ctrl.sv
hw/periph_readback.sv
hw/periph_top.sv
verif/periph_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module periph_tb \
    -o periph_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/periph_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== PASS ===" sim.log; then
    exit 0
else
    echo "Pass line not found in sim.log"
    exit 1
fi
